//--- src/controlUnit_macros.svh
`ifndef CONTROL_UNIT_MACROS_SVH
`define CONTROL_UNIT_MACROS_SVH

// instruction field widths
`define CU_OPCODE_W 6
`define CU_FUNCT_W 6

`define CU_OP_RTYPE 0

// R-type funct codes
`define CU_FN_ADD 32
`define CU_FN_SUB 34
`define CU_FN_AND 36
`define CU_FN_SLT 42
`define CU_FN_RTE 19
`define CU_FN_BREAK 13
`define CU_FN_JR 8
`define CU_FN_SLL 0
`define CU_FN_SLLV 4
`define CU_FN_SRA 3
`define CU_FN_SRAV 7
`define CU_FN_SRL 2

// phase lengths in cycles
`define CU_FETCH_STEPS 3
`define CU_DECODE_STEPS 3

`define CU_STEP_W 2

`endif

//--- src/controlPkg.sv
`include "controlUnit_macros.svh"

package controlPkg;

    typedef logic [`CU_OPCODE_W-1:0] opcode_t;
    typedef logic [`CU_FUNCT_W-1:0] funct_t;
    typedef logic [`CU_STEP_W-1:0] step_t;

    // datapath select and operation fields
    typedef logic [1:0] aluSrc_t;
    typedef logic [2:0] aluOp_t;
    typedef logic [2:0] pcSrc_t;
    typedef logic [1:0] regWriteSel_t;
    typedef logic [3:0] writeDataSel_t;
    typedef logic [1:0] shiftAmtSel_t;
    typedef logic [2:0] shiftOp_t;

    typedef enum logic [2:0] {
        phaseReset,
        phaseFetch,
        phaseIrLoad,
        phaseDecode,
        phaseExec
    } phase_t;

    typedef enum logic [3:0] {
        clsAdd,
        clsSub,
        clsAnd,
        clsSlt,
        clsRte,
        clsBreak,
        clsJr,
        clsSll,
        clsSllv,
        clsSra,
        clsSrav,
        clsSrl,
        clsInvalid
    } instrClass_t;

    // PC, memory and IR controls
    typedef struct packed {
        logic pcWrite;
        pcSrc_t pcSrc;
        logic memWr;
        logic irWrite;
    } fetchCtrl_t;

    // ALU, register file and shifter controls
    typedef struct packed {
        aluSrc_t aluSrcA;
        aluSrc_t aluSrcB;
        aluOp_t aluControl;
        logic aluOutWrite;
        logic regWrite;
        regWriteSel_t regWriteMux;
        writeDataSel_t writeDataCtrl;
        shiftAmtSel_t shiftN;
        logic shiftInput;
        shiftOp_t shiftCtrl;
    } dataCtrl_t;

endpackage

//--- src/instrDecoder.sv
`timescale 1ns/1ps

`include "controlUnit_macros.svh"

module instrDecoder
    import controlPkg::*;
(
    input opcode_t opcode,
    input funct_t funct,
    output instrClass_t instrClass
);

    always_comb begin
        instrClass = clsInvalid;
        // only R-type is dispatched, everything else falls back to fetch
        if (opcode == opcode_t'(`CU_OP_RTYPE)) begin
            case (funct)
                funct_t'(`CU_FN_ADD): begin
                    instrClass = clsAdd;
                end
                funct_t'(`CU_FN_SUB): begin
                    instrClass = clsSub;
                end
                funct_t'(`CU_FN_AND): begin
                    instrClass = clsAnd;
                end
                funct_t'(`CU_FN_SLT): begin
                    instrClass = clsSlt;
                end
                funct_t'(`CU_FN_RTE): begin
                    instrClass = clsRte;
                end
                funct_t'(`CU_FN_BREAK): begin
                    instrClass = clsBreak;
                end
                funct_t'(`CU_FN_JR): begin
                    instrClass = clsJr;
                end
                funct_t'(`CU_FN_SLL): begin
                    instrClass = clsSll;
                end
                funct_t'(`CU_FN_SLLV): begin
                    instrClass = clsSllv;
                end
                funct_t'(`CU_FN_SRA): begin
                    instrClass = clsSra;
                end
                funct_t'(`CU_FN_SRAV): begin
                    instrClass = clsSrav;
                end
                funct_t'(`CU_FN_SRL): begin
                    instrClass = clsSrl;
                end
                default: begin
                    instrClass = clsInvalid;
                end
            endcase
        end
    end

endmodule

//--- src/stepSequencer.sv
`timescale 1ns/1ps

`include "controlUnit_macros.svh"

module stepSequencer
    import controlPkg::*;
(
    input logic clk,
    input logic reset,
    input instrClass_t instrClass,
    output phase_t phase,
    output step_t step,
    output instrClass_t heldClass
);

    localparam step_t FetchLast = step_t'(`CU_FETCH_STEPS - 1);
    localparam step_t DecodeLast = step_t'(`CU_DECODE_STEPS - 1);

    step_t execLast;
    step_t stepNext;

    // last execute step per instruction class
    always_comb begin
        case (heldClass)
            clsAdd, clsSub, clsAnd, clsSlt, clsBreak, clsJr: begin
                execLast = step_t'(1);
            end
            clsSll, clsSllv, clsSra, clsSrav, clsSrl: begin
                execLast = step_t'(2);
            end
            default: begin
                // RTE is a single cycle
                execLast = step_t'(0);
            end
        endcase
    end

    assign stepNext = step + step_t'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= phaseReset;
            step <= '0;
            heldClass <= clsInvalid;
        end else begin
            case (phase)
                phaseReset: begin
                    phase <= phaseFetch;
                    step <= '0;
                end
                phaseFetch: begin
                    if (step == FetchLast) begin
                        phase <= phaseIrLoad;
                        step <= '0;
                    end else begin
                        step <= stepNext;
                    end
                end
                phaseIrLoad: begin
                    phase <= phaseDecode;
                    step <= '0;
                end
                phaseDecode: begin
                    if (step == DecodeLast) begin
                        // class is sampled only at dispatch
                        heldClass <= instrClass;
                        phase <= (instrClass == clsInvalid) ? phaseFetch : phaseExec;
                        step <= '0;
                    end else begin
                        step <= stepNext;
                    end
                end
                phaseExec: begin
                    if (step == execLast) begin
                        phase <= phaseFetch;
                        step <= '0;
                    end else begin
                        step <= stepNext;
                    end
                end
                default: begin
                    phase <= phaseReset;
                    step <= '0;
                end
            endcase
        end
    end

endmodule

//--- src/controlEncoder.sv
`timescale 1ns/1ps

module controlEncoder
    import controlPkg::*;
(
    input phase_t phase,
    input step_t step,
    input instrClass_t heldClass,
    output fetchCtrl_t fetchCtrl,
    output dataCtrl_t dataCtrl,
    output logic resetOut
);

    aluOp_t aluSel;
    shiftOp_t shiftSel;
    logic varShift;

    // ALU operation for the R-type arithmetic group
    always_comb begin
        case (heldClass)
            clsSub: begin
                aluSel = 3'd2;
            end
            clsAnd: begin
                aluSel = 3'd3;
            end
            clsSlt: begin
                aluSel = 3'd7;
            end
            default: begin
                aluSel = 3'd1;
            end
        endcase
    end

    // shifter operation in the shift step
    always_comb begin
        case (heldClass)
            clsSra, clsSrav: begin
                shiftSel = 3'd4;
            end
            clsSrl: begin
                shiftSel = 3'd3;
            end
            default: begin
                shiftSel = 3'd2;
            end
        endcase
    end

    // variable shifts take the amount from rs
    assign varShift = (heldClass == clsSllv) || (heldClass == clsSrav);

    always_comb begin
        fetchCtrl = '0;
        dataCtrl = '0;
        resetOut = 1'b0;
        case (phase)
            phaseReset: begin
                fetchCtrl.irWrite = 1'b1;
                dataCtrl.regWriteMux = 2'd1;
                dataCtrl.writeDataCtrl = 4'd10;
                resetOut = 1'b1;
            end
            phaseFetch: begin
                // memory read while the ALU forms PC+4
                fetchCtrl.memWr = 1'b1;
                dataCtrl.aluSrcB = 2'd1;
                dataCtrl.aluControl = 3'd1;
                dataCtrl.regWriteMux = 2'd1;
            end
            phaseIrLoad: begin
                fetchCtrl.pcWrite = 1'b1;
                fetchCtrl.irWrite = 1'b1;
                dataCtrl.regWriteMux = 2'd1;
            end
            phaseDecode: begin
                if (step == step_t'(0)) begin
                    dataCtrl.aluSrcB = 2'd1;
                    dataCtrl.aluControl = 3'd1;
                    dataCtrl.regWriteMux = 2'd1;
                end else if (step == step_t'(1)) begin
                    dataCtrl.aluOutWrite = 1'b1;
                    dataCtrl.regWriteMux = 2'd1;
                end
            end
            phaseExec: begin
                case (heldClass)
                    clsAdd, clsSub, clsAnd, clsSlt: begin
                        if (step == step_t'(0)) begin
                            dataCtrl.aluSrcA = 2'd2;
                            dataCtrl.aluControl = aluSel;
                        end else if (step == step_t'(1)) begin
                            dataCtrl.regWrite = 1'b1;
                            dataCtrl.regWriteMux = 2'd3;
                            dataCtrl.writeDataCtrl = (heldClass == clsSlt) ? 4'd9 : 4'd5;
                        end
                    end
                    clsRte: begin
                        // return to EPC
                        fetchCtrl.pcWrite = 1'b1;
                        fetchCtrl.pcSrc = 3'd5;
                    end
                    clsBreak: begin
                        if (step == step_t'(0)) begin
                            dataCtrl.aluSrcB = 2'd1;
                            dataCtrl.aluControl = 3'd2;
                        end else if (step == step_t'(1)) begin
                            fetchCtrl.pcWrite = 1'b1;
                        end
                    end
                    clsJr: begin
                        if (step == step_t'(0)) begin
                            dataCtrl.aluSrcA = 2'd2;
                        end else if (step == step_t'(1)) begin
                            fetchCtrl.pcWrite = 1'b1;
                            fetchCtrl.pcSrc = 3'd5;
                        end
                    end
                    clsSll, clsSllv, clsSra, clsSrav, clsSrl: begin
                        if (step == step_t'(0)) begin
                            // load the shifter
                            dataCtrl.shiftCtrl = 3'd1;
                            if (varShift) begin
                                dataCtrl.shiftN = 2'd2;
                                dataCtrl.shiftInput = 1'b1;
                            end
                        end else if (step == step_t'(1)) begin
                            dataCtrl.shiftCtrl = shiftSel;
                        end else if (step == step_t'(2)) begin
                            dataCtrl.regWrite = 1'b1;
                            dataCtrl.regWriteMux = 2'd3;
                            dataCtrl.writeDataCtrl = 4'd7;
                        end
                    end
                    default: begin
                        fetchCtrl = '0;
                    end
                endcase
            end
            default: begin
                resetOut = 1'b0;
            end
        endcase
    end

endmodule

//--- src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
    import controlPkg::*;
(
    input logic clk,
    input logic reset,
    input opcode_t opcode,
    input funct_t funct,
    output fetchCtrl_t fetchCtrl,
    output dataCtrl_t dataCtrl,
    output logic resetOut
);

    instrClass_t instrClass;
    instrClass_t heldClass;
    phase_t phase;
    step_t step;

    instrDecoder decoder (
        .opcode(opcode),
        .funct(funct),
        .instrClass(instrClass)
    );

    // phase and step state
    stepSequencer sequencer (
        .clk(clk),
        .reset(reset),
        .instrClass(instrClass),
        .phase(phase),
        .step(step),
        .heldClass(heldClass)
    );

    controlEncoder encoder (
        .phase(phase),
        .step(step),
        .heldClass(heldClass),
        .fetchCtrl(fetchCtrl),
        .dataCtrl(dataCtrl),
        .resetOut(resetOut)
    );

endmodule

//--- sim/controlModel.svh
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// positions within one instruction, counted from fetch step 0
localparam int IrLoadPos = `CU_FETCH_STEPS;
localparam int DispatchPos = IrLoadPos + `CU_DECODE_STEPS;
localparam int ExecFirst = DispatchPos + 1;

logic inReset = 1'b1;
int position = 0;
funct_t heldFunct = '0;
int heldExecLen = 0;
int instrDone = 0;

// execute cycles per instruction, zero means back to fetch
function automatic int execLength(input opcode_t op, input funct_t fn);
    if (op != opcode_t'(`CU_OP_RTYPE)) begin
        return 0;
    end
    case (fn)
        funct_t'(`CU_FN_ADD), funct_t'(`CU_FN_SUB), funct_t'(`CU_FN_AND),
        funct_t'(`CU_FN_SLT), funct_t'(`CU_FN_BREAK), funct_t'(`CU_FN_JR): begin
            return 2;
        end
        funct_t'(`CU_FN_RTE): begin
            return 1;
        end
        funct_t'(`CU_FN_SLL), funct_t'(`CU_FN_SLLV), funct_t'(`CU_FN_SRA),
        funct_t'(`CU_FN_SRAV), funct_t'(`CU_FN_SRL): begin
            return 3;
        end
        default: begin
            return 0;
        end
    endcase
endfunction

// one clock edge of the reference sequence
task automatic advanceModel(input logic rst, input opcode_t op, input funct_t fn);
    int len;
    len = execLength(op, fn);
    if (rst) begin
        inReset = 1'b1;
        position = 0;
    end else if (inReset) begin
        inReset = 1'b0;
        position = 0;
    end else if (position == DispatchPos) begin
        heldFunct = fn;
        heldExecLen = len;
        if (len == 0) begin
            position = 0;
            instrDone++;
        end else begin
            position = ExecFirst;
        end
    end else if (position >= ExecFirst && position - ExecFirst == heldExecLen - 1) begin
        position = 0;
        instrDone++;
    end else begin
        position++;
    end
endtask

function automatic string describeState();
    if (inReset) begin
        return "reset";
    end
    if (position < IrLoadPos) begin
        return $sformatf("fetch step %0d", position);
    end
    if (position == IrLoadPos) begin
        return "ir load";
    end
    if (position <= DispatchPos) begin
        return $sformatf("decode step %0d", position - IrLoadPos - 1);
    end
    return $sformatf("exec funct %0d step %0d", heldFunct, position - ExecFirst);
endfunction

`endif

//--- sim/controlUnitTb.sv
`timescale 1ns/1ps

`include "controlUnit_macros.svh"

module controlUnitTb
    import controlPkg::*;
();

    localparam int NumInstr = 400;
    localparam int CycleLimit = 6000;
    localparam int ResetWaitLimit = 4;
    localparam logic [31:0] Seed = 32'h3eb722cf;

    logic clk;
    logic reset;
    opcode_t opcode;
    funct_t funct;
    fetchCtrl_t fetchCtrl;
    dataCtrl_t dataCtrl;
    logic resetOut;

    logic [31:0] rngState;
    int fetchErrors = 0;
    int dataErrors = 0;
    int resetErrors = 0;
    int otherErrors = 0;

    `include "controlModel.svh"

    controlUnit dut_i (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .funct(funct),
        .fetchCtrl(fetchCtrl),
        .dataCtrl(dataCtrl),
        .resetOut(resetOut)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // expected PC, memory and IR word from the control table
    function automatic fetchCtrl_t fetchWordNow();
        fetchCtrl_t f;
        int e;
        f = '0;
        e = position - ExecFirst;
        if (inReset) begin
            f.irWrite = 1'b1;
        end else if (position < IrLoadPos) begin
            f.memWr = 1'b1;
        end else if (position == IrLoadPos) begin
            f.pcWrite = 1'b1;
            f.irWrite = 1'b1;
        end else if (position >= ExecFirst) begin
            case (heldFunct)
                funct_t'(`CU_FN_RTE): begin
                    f.pcWrite = 1'b1;
                    f.pcSrc = 3'd5;
                end
                funct_t'(`CU_FN_BREAK): begin
                    f.pcWrite = (e == 1);
                end
                funct_t'(`CU_FN_JR): begin
                    if (e == 1) begin
                        f.pcWrite = 1'b1;
                        f.pcSrc = 3'd5;
                    end
                end
                default: begin
                    f = '0;
                end
            endcase
        end
        return f;
    endfunction

    // expected ALU, register file and shifter word
    function automatic dataCtrl_t dataWordNow();
        dataCtrl_t d;
        int e;
        d = '0;
        e = position - ExecFirst;
        if (inReset) begin
            d.regWriteMux = 2'd1;
            d.writeDataCtrl = 4'd10;
        end else if (position < IrLoadPos || position == IrLoadPos + 1) begin
            d.aluSrcB = 2'd1;
            d.aluControl = 3'd1;
            d.regWriteMux = 2'd1;
        end else if (position == IrLoadPos) begin
            d.regWriteMux = 2'd1;
        end else if (position == IrLoadPos + 2) begin
            d.aluOutWrite = 1'b1;
            d.regWriteMux = 2'd1;
        end else if (position >= ExecFirst) begin
            case (heldFunct)
                funct_t'(`CU_FN_ADD), funct_t'(`CU_FN_SUB), funct_t'(`CU_FN_AND),
                funct_t'(`CU_FN_SLT): begin
                    if (e == 0) begin
                        d.aluSrcA = 2'd2;
                        d.aluControl = (heldFunct == funct_t'(`CU_FN_ADD)) ? 3'd1 :
                                       (heldFunct == funct_t'(`CU_FN_SUB)) ? 3'd2 :
                                       (heldFunct == funct_t'(`CU_FN_AND)) ? 3'd3 : 3'd7;
                    end else begin
                        d.regWrite = 1'b1;
                        d.regWriteMux = 2'd3;
                        d.writeDataCtrl = (heldFunct == funct_t'(`CU_FN_SLT)) ? 4'd9 : 4'd5;
                    end
                end
                funct_t'(`CU_FN_BREAK): begin
                    if (e == 0) begin
                        d.aluSrcB = 2'd1;
                        d.aluControl = 3'd2;
                    end
                end
                funct_t'(`CU_FN_JR): begin
                    if (e == 0) begin
                        d.aluSrcA = 2'd2;
                    end
                end
                funct_t'(`CU_FN_SLL), funct_t'(`CU_FN_SLLV), funct_t'(`CU_FN_SRA),
                funct_t'(`CU_FN_SRAV), funct_t'(`CU_FN_SRL): begin
                    if (e == 0) begin
                        d.shiftCtrl = 3'd1;
                        if (heldFunct == funct_t'(`CU_FN_SLLV)
                                || heldFunct == funct_t'(`CU_FN_SRAV)) begin
                            d.shiftN = 2'd2;
                            d.shiftInput = 1'b1;
                        end
                    end else if (e == 1) begin
                        d.shiftCtrl = (heldFunct == funct_t'(`CU_FN_SRL)) ? 3'd3 :
                                      (heldFunct == funct_t'(`CU_FN_SRA)
                                       || heldFunct == funct_t'(`CU_FN_SRAV)) ? 3'd4 : 3'd2;
                    end else begin
                        d.regWrite = 1'b1;
                        d.regWriteMux = 2'd3;
                        d.writeDataCtrl = 4'd7;
                    end
                end
                default: begin
                    d = '0;
                end
            endcase
        end
        return d;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic funct_t keptFunct(input int idx);
        case (idx)
            0: return funct_t'(`CU_FN_ADD);
            1: return funct_t'(`CU_FN_SUB);
            2: return funct_t'(`CU_FN_AND);
            3: return funct_t'(`CU_FN_SLT);
            4: return funct_t'(`CU_FN_RTE);
            5: return funct_t'(`CU_FN_BREAK);
            6: return funct_t'(`CU_FN_JR);
            7: return funct_t'(`CU_FN_SLL);
            8: return funct_t'(`CU_FN_SLLV);
            9: return funct_t'(`CU_FN_SRA);
            10: return funct_t'(`CU_FN_SRAV);
            default: return funct_t'(`CU_FN_SRL);
        endcase
    endfunction

    // mostly kept R-type codes, a quarter fully random
    task automatic drawInstruction();
        rngState = xorshift32(rngState);
        if (rngState[1:0] != 2'd0) begin
            opcode = opcode_t'(`CU_OP_RTYPE);
            funct = keptFunct(int'(rngState[15:8]) % 12);
        end else begin
            opcode = rngState[13:8];
            funct = rngState[21:16];
        end
    endtask

    task automatic checkFetch(input string name, input fetchCtrl_t exp, input fetchCtrl_t act);
        if (act !== exp) begin
            $display("error %s: fetchCtrl expected %h actual %h", name, exp, act);
            fetchErrors++;
        end
    endtask

    task automatic compareData(input string name, input dataCtrl_t exp, input dataCtrl_t act);
        if (act !== exp) begin
            $display("error %s: dataCtrl expected %h actual %h", name, exp, act);
            dataErrors++;
        end
    endtask

    task automatic verifyResetOut(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s: resetOut expected %b actual %b", name, exp, act);
            resetErrors++;
        end
    endtask

    // one clock: model edge, new inputs, then check at the falling edge
    task automatic runCycle(input logic resetNext);
        @(posedge clk);
        advanceModel(reset, opcode, funct);
        #1;
        reset = resetNext;
        drawInstruction();
        @(negedge clk);
        checkFetch(describeState(), fetchWordNow(), fetchCtrl);
        compareData(describeState(), dataWordNow(), dataCtrl);
        verifyResetOut(describeState(), inReset, resetOut);
    endtask

    initial begin
        int waitCount;
        int cycles;
        int totalErrors;
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        rngState = Seed;
        runCycle(1'b1);
        runCycle(1'b0);
        waitCount = 0;
        while (resetOut !== 1'b0 && waitCount < ResetWaitLimit) begin
            runCycle(1'b0);
            waitCount++;
        end
        if (resetOut !== 1'b0) begin
            $display("timeout: resetOut still high %0d cycles after reset release", waitCount);
            otherErrors++;
        end else begin
            cycles = 0;
            while (instrDone < NumInstr && cycles < CycleLimit) begin
                runCycle(1'b0);
                cycles++;
            end
            if (instrDone < NumInstr) begin
                $display("timeout: only %0d instructions done in %0d cycles", instrDone, cycles);
                otherErrors++;
            end
        end
        totalErrors = fetchErrors + dataErrors + resetErrors + otherErrors;
        $display("instructions %0d, errors fetchCtrl %0d dataCtrl %0d resetOut %0d other %0d",
                 instrDone, fetchErrors, dataErrors, resetErrors, otherErrors);
        if (totalErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+src
+incdir+sim
src/controlPkg.sv
src/instrDecoder.sv
src/stepSequencer.sv
src/controlEncoder.sv
src/controlUnit.sv
sim/controlUnitTb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log &&
verilator --binary --timing -f sources.f --top-module controlUnitTb -o controlUnitSim &&
./obj_dir/controlUnitSim | tee sim.log
grep -qxF '** PASS **' sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
